// ==== Makefile ====
TOP = tb_qpsk_link

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench into sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Done: errors found" >> sim.log
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log

// ==== conv_encoder.sv ====
`timescale 1ns/1ps
module conv_encoder (
    input  logic            CLOCK_256,
    input  logic            reset,
    input  logic            tx_start,
    input  link_pkg::data_t tx_data,
    input  link_pkg::poly_t g1,
    input  link_pkg::poly_t g2,
    input  logic            code_ready,
    output logic            enc_busy,
    output logic            code_valid,
    output link_pkg::code_t code_word
);
    import link_pkg::*;

    logic                 running;   // shifting data bits
    logic [bit_idx_w-1:0] bit_cnt;
    logic                 start;
    data_t                data_q;    // lsb is the current bit
    poly_t                g1_q;
    poly_t                g2_q;
    logic [k_len-2:0]     hist;      // six previous bits, newest at 0
    logic [k_len-1:0]     window;
    code_t                code_q;

    assign start     = tx_start & ~enc_busy;
    assign window    = {hist, data_q[0]};  // new bit in position 0
    assign enc_busy  = running | code_valid;
    assign code_word = code_q;

    // ------------------------------------------------------------------
    // frame control
    // ------------------------------------------------------------------
    always_ff @(posedge CLOCK_256 or posedge reset) begin
        if (reset) begin
            running    <= 1'b0;
            code_valid <= 1'b0;
            bit_cnt    <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                bit_cnt <= '0;
            end else if (running) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == bit_idx_w'(data_w - 1)) begin
                    running    <= 1'b0;
                    code_valid <= 1'b1;  // up the cycle after bit 15
                end
            end
            if (code_valid && code_ready) begin
                code_valid <= 1'b0;  // mapper took it
            end
        end
    end

    // shift path, pair n lands at bits 2n+1:2n after 16 shifts
    always_ff @(posedge CLOCK_256) begin
        if (start) begin
            data_q <= tx_data;
            g1_q   <= g1;
            g2_q   <= g2;
            hist   <= '0;  // state cleared per frame
        end else if (running) begin
            data_q <= data_q >> 1;
            hist   <= window[k_len-2:0];
            code_q <= {^(window & g2_q), ^(window & g1_q), code_q[code_w-1:2]};
        end
    end

endmodule

// ==== files.f ====
link_pkg.sv
regmap_pkg.sv
link_regs.sv
conv_encoder.sv
qpsk_mapper.sv
qpsk_demapper.sv
qpsk_link_top.sv
qpsk_link_asserts.sv
tb_clock_gen.sv
tb_qpsk_link.sv

// ==== link_pkg.sv ====
package link_pkg;

    // ------------------------------------------------------------------
    // frame geometry
    // ------------------------------------------------------------------
    localparam int data_w    = 16;               // one data word per frame
    localparam int code_w    = 32;               // rate 1/2 codeword
    localparam int k_len     = 7;                // constraint length
    localparam int n_sym     = 16;               // qpsk symbols per codeword
    localparam int sym_idx_w = $clog2(n_sym);    // symbol index width
    localparam int bit_idx_w = $clog2(data_w);   // encoder bit counter width

    typedef logic [data_w-1:0] data_t;
    typedef logic [code_w-1:0] code_t;
    typedef logic [k_len-1:0]  poly_t;
    typedef logic [1:0]        comp_t;   // two's complement, 10 never legal
    typedef logic [1:0]        pair_t;   // two coded bits per symbol
    typedef logic [7:0]        erase_t;  // saturating erasure count

    // symbol component levels
    localparam comp_t comp_pos  = 2'b01;  // +1
    localparam comp_t comp_zero = 2'b00;
    localparam comp_t comp_neg  = 2'b11;  // -1

    // one symbol, either as i/q fields or as a raw nibble (i on top)
    typedef union packed {
        struct packed {
            comp_t i;
            comp_t q;
        } iq;
        logic [3:0] raw;
    } qpsk_sym_u;

    // legal raw nibbles, named by the pair they carry
    localparam logic [3:0] raw_00 = {comp_pos, comp_zero};   // (+1, 0)
    localparam logic [3:0] raw_01 = {comp_zero, comp_pos};   // (0, +1)
    localparam logic [3:0] raw_11 = {comp_neg, comp_zero};   // (-1, 0)
    localparam logic [3:0] raw_10 = {comp_zero, comp_neg};   // (0, -1)

endpackage

// ==== link_regs.sv ====
`timescale 1ns/1ps
module link_regs (
    input  logic              CLOCK_256,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  regmap_pkg::addr_t paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              enc_busy,
    input  logic              map_busy,
    input  link_pkg::code_t   rx_word,
    input  logic              rx_done,
    input  logic              erase_inc,
    output logic              tx_start,
    output link_pkg::data_t   tx_data,
    output link_pkg::poly_t   g1,
    output link_pkg::poly_t   g2
);
    import link_pkg::*;
    import regmap_pkg::*;

    logic   access;      // apb access phase
    logic   wr_en;
    logic   rd_en;
    logic   mapped;      // address decodes to a register
    logic   read_only;
    logic   go;          // accepted frame start
    code_t  rx_word_q;
    logic   rx_valid_q;
    erase_t erase_cnt;

    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign rd_en  = access & ~pwrite;
    assign pready = 1'b1;  // no wait states
    assign pslverr = access & (~mapped | (pwrite & read_only));

    // write while encoder busy is taken on the bus but dropped here
    assign go = wr_en && (paddr == reg_tx_data) && !enc_busy && !tx_start;

    // ------------------------------------------------------------------
    // read mux and address decode
    // ------------------------------------------------------------------
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        prdata    = '0;
        case (paddr)
            reg_tx_data:  prdata = '0;  // write only, reads back zero
            reg_poly: begin
                prdata[poly_g1_lsb +: k_len] = g1;
                prdata[poly_g2_lsb +: k_len] = g2;
            end
            reg_status: begin
                read_only              = 1'b1;
                prdata[st_enc_busy]    = enc_busy;
                prdata[st_map_busy]    = map_busy;
                prdata[st_rx_valid]    = rx_valid_q;
            end
            reg_rx_word: begin
                read_only = 1'b1;
                prdata    = rx_word_q;
            end
            reg_erasures: prdata = 32'(erase_cnt);
            default:      mapped = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // control and config registers
    // ------------------------------------------------------------------
    always_ff @(posedge CLOCK_256 or posedge reset) begin
        if (reset) begin
            tx_start   <= 1'b0;
            g1         <= poly_g1_rst;
            g2         <= poly_g2_rst;
            rx_word_q  <= '0;
            rx_valid_q <= 1'b0;
            erase_cnt  <= '0;
        end else begin
            tx_start <= go;  // one cycle pulse

            if (wr_en && paddr == reg_poly) begin
                g1 <= pwdata[poly_g1_lsb +: k_len];
                g2 <= pwdata[poly_g2_lsb +: k_len];
            end

            // new word beats a clearing read in the same cycle
            if (rx_done) begin
                rx_word_q  <= rx_word;
                rx_valid_q <= 1'b1;
            end else if (rd_en && paddr == reg_rx_word) begin
                rx_valid_q <= 1'b0;
            end

            if (wr_en && paddr == reg_erasures) begin
                erase_cnt <= '0;
            end else if (erase_inc && erase_cnt != '1) begin
                erase_cnt <= erase_cnt + 1'b1;  // stops at 255
            end
        end
    end

    // data word goes out with the start pulse
    always_ff @(posedge CLOCK_256) begin
        if (go) begin
            tx_data <= pwdata[data_w-1:0];
        end
    end

endmodule

// ==== qpsk_demapper.sv ====
`timescale 1ns/1ps
module qpsk_demapper (
    input  logic            CLOCK_256,
    input  logic            reset,
    input  logic            rx_valid,
    input  link_pkg::comp_t rx_i,
    input  link_pkg::comp_t rx_q,
    output link_pkg::code_t rx_word,
    output logic            rx_done,
    output logic            erase_inc
);
    import link_pkg::*;

    qpsk_sym_u            sym;
    pair_t                pair;
    logic                 erased;    // not one of the four points
    logic [sym_idx_w-1:0] sym_idx;
    logic                 last_sym;
    code_t                asm_q;     // word under assembly
    code_t                asm_next;

    // fields in, raw nibble decoded
    always_comb begin
        sym.iq.i = rx_i;
        sym.iq.q = rx_q;
        erased   = 1'b0;
        case (sym.raw)
            raw_00:  pair = 2'b00;
            raw_01:  pair = 2'b01;
            raw_11:  pair = 2'b11;
            raw_10:  pair = 2'b10;
            default: begin
                pair   = 2'b00;  // erasure slot reads as zero
                erased = 1'b1;
            end
        endcase
    end

    // drop the pair into its slot
    always_comb begin
        asm_next                  = asm_q;
        asm_next[2*sym_idx +: 2]  = pair;
    end

    assign last_sym = (sym_idx == sym_idx_w'(n_sym - 1));

    // ------------------------------------------------------------------
    // symbol counter and pulses
    // ------------------------------------------------------------------
    always_ff @(posedge CLOCK_256 or posedge reset) begin
        if (reset) begin
            sym_idx   <= '0;
            rx_done   <= 1'b0;
            erase_inc <= 1'b0;
        end else begin
            rx_done   <= rx_valid & last_sym;
            erase_inc <= rx_valid & erased;
            if (rx_valid) begin
                sym_idx <= sym_idx + 1'b1;  // wraps at 16
            end
        end
    end

    always_ff @(posedge CLOCK_256) begin
        if (rx_valid) begin
            asm_q <= asm_next;
            if (last_sym) begin
                rx_word <= asm_next;  // visible with rx_done
            end
        end
    end

endmodule

// ==== qpsk_link_asserts.sv ====
`timescale 1ns/1ps
module qpsk_link_asserts (
    input logic            CLOCK_256,
    input logic            reset,
    input logic            pready,
    input logic            tx_valid,
    input link_pkg::comp_t tx_i,
    input link_pkg::comp_t tx_q
);
    import link_pkg::*;

    logic [4:0] run_len;  // tx_valid cycles seen so far in this burst

    always_ff @(posedge CLOCK_256 or posedge reset) begin
        if (reset) begin
            run_len <= '0;
        end else if (tx_valid) begin
            run_len <= run_len + 5'd1;
        end else begin
            run_len <= '0;
        end
    end

    // ------------------------------------------------------------------
    // bus and symbol rules
    // ------------------------------------------------------------------
    pready_high: assert property (@(posedge CLOCK_256) pready)
        else $error("pready went low");

    tx_legal: assert property (@(posedge CLOCK_256) disable iff (reset)
        (tx_i != 2'b10) && (tx_q != 2'b10))
        else $error("tx component carries the unused code 10");

    // burst length, never past 16 and never cut short
    burst_max: assert property (@(posedge CLOCK_256) disable iff (reset)
        tx_valid |-> run_len < 5'(n_sym))
        else $error("tx_valid burst longer than 16 cycles");

    burst_len: assert property (@(posedge CLOCK_256) disable iff (reset)
        (!tx_valid && run_len != 5'd0) |-> run_len == 5'(n_sym))
        else $error("tx_valid burst ended early");

    quiet_in_reset: assert property (@(posedge CLOCK_256) reset |-> !tx_valid)
        else $error("tx_valid high during reset");

endmodule

bind qpsk_link_top qpsk_link_asserts qpsk_link_asserts_i (
    .CLOCK_256 (CLOCK_256),
    .reset     (reset),
    .pready    (pready),
    .tx_valid  (tx_valid),
    .tx_i      (tx_i),
    .tx_q      (tx_q)
);

// ==== qpsk_link_top.sv ====
`timescale 1ns/1ps
module qpsk_link_top (
    input  logic              CLOCK_256,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  regmap_pkg::addr_t paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              tx_valid,
    output link_pkg::comp_t   tx_i,
    output link_pkg::comp_t   tx_q,
    input  logic              rx_valid,
    input  link_pkg::comp_t   rx_i,
    input  link_pkg::comp_t   rx_q
);
    import link_pkg::*;

    logic  tx_start;
    data_t tx_data;
    poly_t g1;
    poly_t g2;
    logic  enc_busy;
    logic  map_busy;
    logic  code_valid;    // encoder to mapper handshake
    logic  code_ready;
    code_t code_word;
    code_t rx_word;
    logic  rx_done;
    logic  erase_inc;

    // ------------------------------------------------------------------
    // register block
    // ------------------------------------------------------------------
    link_regs link_regs_i (
        .CLOCK_256 (CLOCK_256),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enc_busy  (enc_busy),
        .map_busy  (map_busy),
        .rx_word   (rx_word),
        .rx_done   (rx_done),
        .erase_inc (erase_inc),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .g1        (g1),
        .g2        (g2)
    );

    // ------------------------------------------------------------------
    // transmit side
    // ------------------------------------------------------------------
    conv_encoder conv_encoder_i (
        .CLOCK_256  (CLOCK_256),
        .reset      (reset),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .g1         (g1),
        .g2         (g2),
        .code_ready (code_ready),
        .enc_busy   (enc_busy),
        .code_valid (code_valid),
        .code_word  (code_word)
    );

    qpsk_mapper qpsk_mapper_i (
        .CLOCK_256  (CLOCK_256),
        .reset      (reset),
        .code_valid (code_valid),
        .code_word  (code_word),
        .code_ready (code_ready),
        .map_busy   (map_busy),
        .tx_valid   (tx_valid),
        .tx_i       (tx_i),
        .tx_q       (tx_q)
    );

    // receive side, channel is outside
    qpsk_demapper qpsk_demapper_i (
        .CLOCK_256 (CLOCK_256),
        .reset     (reset),
        .rx_valid  (rx_valid),
        .rx_i      (rx_i),
        .rx_q      (rx_q),
        .rx_word   (rx_word),
        .rx_done   (rx_done),
        .erase_inc (erase_inc)
    );

endmodule

// ==== qpsk_mapper.sv ====
`timescale 1ns/1ps
module qpsk_mapper (
    input  logic            CLOCK_256,
    input  logic            reset,
    input  logic            code_valid,
    input  link_pkg::code_t code_word,
    output logic            code_ready,
    output logic            map_busy,
    output logic            tx_valid,
    output link_pkg::comp_t tx_i,
    output link_pkg::comp_t tx_q
);
    import link_pkg::*;

    code_t                word_q;
    logic                 sending;
    logic [sym_idx_w-1:0] sym_idx;
    pair_t                pair;
    qpsk_sym_u            sym;

    assign code_ready = ~sending;  // take a word only when idle
    assign map_busy   = sending;
    assign tx_valid   = sending;
    assign pair       = word_q[2*sym_idx +: 2];

    // pair to constellation point
    always_comb begin
        sym = '0;
        case (pair)
            2'b00: begin
                sym.iq.i = comp_pos;
                sym.iq.q = comp_zero;
            end
            2'b01: begin
                sym.iq.i = comp_zero;
                sym.iq.q = comp_pos;
            end
            2'b11: begin
                sym.iq.i = comp_neg;
                sym.iq.q = comp_zero;
            end
            default: begin  // 10
                sym.iq.i = comp_zero;
                sym.iq.q = comp_neg;
            end
        endcase
    end

    assign tx_i = sym.iq.i;
    assign tx_q = sym.iq.q;

    always_ff @(posedge CLOCK_256 or posedge reset) begin
        if (reset) begin
            sending <= 1'b0;
            sym_idx <= '0;
            word_q  <= '0;
        end else if (code_valid && code_ready) begin
            word_q  <= code_word;
            sending <= 1'b1;  // 16 symbols from next cycle
            sym_idx <= '0;
        end else if (sending) begin
            sym_idx <= sym_idx + 1'b1;
            if (sym_idx == sym_idx_w'(n_sym - 1)) begin
                sending <= 1'b0;
            end
        end
    end

endmodule

// ==== regmap_pkg.sv ====
package regmap_pkg;

    typedef logic [7:0] addr_t;

    // ------------------------------------------------------------------
    // register addresses
    // ------------------------------------------------------------------
    localparam addr_t reg_tx_data  = 8'h00;  // wo, write starts a frame
    localparam addr_t reg_poly     = 8'h04;  // rw, g1 and g2
    localparam addr_t reg_status   = 8'h08;  // ro
    localparam addr_t reg_rx_word  = 8'h0C;  // ro, read clears rx_valid
    localparam addr_t reg_erasures = 8'h10;  // read count, write clears

    // reg_poly fields
    localparam int         poly_g1_lsb = 0;            // bits 6:0
    localparam int         poly_g2_lsb = 8;            // bits 14:8
    localparam logic [6:0] poly_g1_rst = 7'b1011011;
    localparam logic [6:0] poly_g2_rst = 7'b1111001;

    // reg_status bits
    localparam int st_enc_busy = 0;
    localparam int st_map_busy = 1;
    localparam int st_rx_valid = 2;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
module tb_clock_gen (
    output logic CLOCK_256,
    output logic reset
);

    // 100 ns period
    initial begin
        CLOCK_256 = 1'b0;
        forever #50 CLOCK_256 = ~CLOCK_256;
    end

    // reset held over the first 4 rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge CLOCK_256);
        #5;
        reset = 1'b0;  // released with the stimulus skew
    end

endmodule

// ==== tb_qpsk_link.sv ====
`timescale 1ns/1ps
module tb_qpsk_link;
    import link_pkg::*;
    import regmap_pkg::*;

    localparam int n_rows      = 8;
    localparam int cycle_limit = n_rows * 60 + 200;  // frame plus bus traffic per row
    localparam int no_bad      = -1;

    logic        CLOCK_256;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    addr_t       paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        tx_valid;
    comp_t       tx_i;
    comp_t       tx_q;
    logic        rx_valid = 1'b0;  // channel side, loopback only
    comp_t       rx_i     = 2'b00;
    comp_t       rx_q     = 2'b00;

    // stimulus table, one frame per row
    data_t  tbl_data  [n_rows];
    poly_t  tbl_g1    [n_rows];
    poly_t  tbl_g2    [n_rows];
    int     tbl_bad   [n_rows];  // corrupted symbol or no_bad
    erase_t tbl_erase [n_rows];  // expected erasure step

    code_t     cur_code   = '0;      // clean word of the frame in flight
    int        bad_idx    = no_bad;
    int        frame_base = 0;       // tot_syms at frame start
    int        tot_syms   = 0;
    logic      lb_valid   = 1'b0;    // loopback stage
    qpsk_sym_u lb_sym     = '0;
    logic [31:0] rng;
    int        cycles     = 0;

    tb_clock_gen clock_gen_i (
        .CLOCK_256 (CLOCK_256),
        .reset     (reset)
    );

    qpsk_link_top qpsk_link_top_i (
        .CLOCK_256 (CLOCK_256),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tx_valid  (tx_valid),
        .tx_i      (tx_i),
        .tx_q      (tx_q),
        .rx_valid  (rx_valid),
        .rx_i      (rx_i),
        .rx_q      (rx_q)
    );

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic code_t ref_encode(input data_t d, input poly_t a, input poly_t b);
        logic [5:0] past;
        logic [6:0] win;
        code_t      c;
        int         n;
        past = '0;  // fresh state per frame
        c    = '0;
        for (n = 0; n < data_w; n++) begin
            win      = {past, d[n]};  // new bit at 0
            c[2*n]   = ^(win & a);
            c[2*n+1] = ^(win & b);
            past     = win[5:0];
        end
        return c;
    endfunction

    // pair to point, i in the upper half of raw
    function automatic qpsk_sym_u map_pair(input pair_t p);
        qpsk_sym_u s;
        case (p)
            2'b00:   s.raw = 4'b0100;  // (+1, 0)
            2'b01:   s.raw = 4'b0001;  // (0, +1)
            2'b11:   s.raw = 4'b1100;  // (-1, 0)
            default: s.raw = 4'b0011;  // (0, -1)
        endcase
        return s;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------
    task automatic check_code(input string name, input code_t want, input code_t got);
        if (got !== want) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, want, got);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_erase(input string name, input erase_t want, input erase_t got);
        if (got !== want) begin
            $display("ERR t=%0t %s expected %0d actual %0d", $time, name, want, got);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_sym(input string name, input qpsk_sym_u want, input qpsk_sym_u got);
        if (got.raw !== want.raw) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, want.raw, got.raw);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, want, got);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped on a protocol failure");
    endtask

    // ------------------------------------------------------------------
    // apb master, setup then access then idle
    // ------------------------------------------------------------------
    task automatic apb_write(input addr_t addr, input logic [31:0] data, input logic exp_err);
        @(posedge CLOCK_256);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge CLOCK_256);
        #5;
        penable = 1'b1;
        @(negedge CLOCK_256);
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);  // mid access phase
        @(posedge CLOCK_256);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input addr_t addr, input logic exp_err, output logic [31:0] data);
        @(posedge CLOCK_256);
        #5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge CLOCK_256);
        #5;
        penable = 1'b1;
        @(negedge CLOCK_256);
        data = prdata;
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);
        @(posedge CLOCK_256);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // polls status, the cycle counter bounds it
    task automatic wait_rx_valid();
        logic [31:0] st;
        st = '0;
        while (st[st_rx_valid] !== 1'b1) begin
            apb_read(reg_status, 1'b0, st);
        end
    endtask

    task automatic set_row(input int r, input data_t d, input poly_t a, input poly_t b,
                           input int bad, input erase_t e);
        tbl_data[r]  = d;
        tbl_g1[r]    = a;
        tbl_g2[r]    = b;
        tbl_bad[r]   = bad;
        tbl_erase[r] = e;
    endtask

    task automatic fill_table();
        set_row(0, 16'h0000, poly_g1_rst, poly_g2_rst, no_bad, 8'd0);
        set_row(1, 16'hA5C3, poly_g1_rst, poly_g2_rst, no_bad, 8'd0);
        rng = xorshift32(rng);
        set_row(2, rng[15:0], poly_g1_rst, poly_g2_rst, no_bad, 8'd0);  // filler
        rng = xorshift32(rng);
        set_row(3, rng[15:0], poly_g1_rst, poly_g2_rst, no_bad, 8'd0);
        set_row(4, 16'h1234, 7'b1111001, 7'b1011011, no_bad, 8'd0);    // swapped polys
        set_row(5, 16'hBEEF, 7'b1110101, 7'b0110011, no_bad, 8'd0);
        set_row(6, 16'hFFFF, poly_g1_rst, poly_g2_rst, 5, 8'd1);       // one erasure
        rng = xorshift32(rng);
        set_row(7, rng[15:0], poly_g1_rst, poly_g2_rst, 15, 8'd1);     // last symbol hit
    endtask

    // ------------------------------------------------------------------
    // loopback channel, one cycle of delay
    // ------------------------------------------------------------------
    always @(negedge CLOCK_256) begin
        qpsk_sym_u seen;
        qpsk_sym_u want;
        int        k;
        seen.iq.i = tx_i;
        seen.iq.q = tx_q;
        k         = tot_syms - frame_base;  // symbol index in frame
        lb_valid  = tx_valid;
        lb_sym    = seen;
        if (tx_valid) begin
            if (k >= n_sym) begin
                stop_run("tx_valid stayed high for more than 16 symbols in one frame");
            end else begin
                want = map_pair(cur_code[2*k +: 2]);
                check_sym("tx_sym", want, seen);
                if (k == bad_idx) begin
                    lb_sym.raw = 4'b1010;  // 10 on both rails
                end
            end
            tot_syms = tot_syms + 1;
        end
    end

    always @(posedge CLOCK_256) begin
        #5;
        rx_valid = lb_valid;
        rx_i     = lb_sym.iq.i;
        rx_q     = lb_sym.iq.q;
    end

    // run limit
    always @(posedge CLOCK_256) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "run timed out");
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] poly_snap;
        logic [31:0] stat_snap;
        logic [31:0] word_snap;
        logic [31:0] erase_snap;
        code_t       exp_code;
        erase_t      exp_erase;
        int          r;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rng       = 32'd63006;
        exp_erase = '0;
        fill_table();
        @(negedge reset);

        // reset values
        @(negedge CLOCK_256);
        check_bit("tx_valid", 1'b0, tx_valid);
        apb_read(reg_poly, 1'b0, rd);
        check_code("reg_poly", {17'b0, 7'b1111001, 1'b0, 7'b1011011}, rd);
        apb_read(reg_status, 1'b0, rd);
        check_code("reg_status", '0, rd);
        apb_read(reg_erasures, 1'b0, rd);
        check_erase("reg_erasures", '0, rd[7:0]);

        for (r = 0; r < n_rows; r++) begin
            apb_write(reg_poly, {17'b0, tbl_g2[r], 1'b0, tbl_g1[r]}, 1'b0);
            exp_code   = ref_encode(tbl_data[r], tbl_g1[r], tbl_g2[r]);
            cur_code   = exp_code;  // tx side sees the clean word
            bad_idx    = tbl_bad[r];
            frame_base = tot_syms;
            apb_write(reg_tx_data, {16'b0, tbl_data[r]}, 1'b0);
            wait_rx_valid();
            if (tot_syms - frame_base != n_sym) begin
                stop_run($sformatf("frame %0d sent %0d symbols instead of 16",
                                   r, tot_syms - frame_base));
            end
            if (tbl_bad[r] != no_bad) begin
                exp_code[2*tbl_bad[r] +: 2] = 2'b00;  // erased pair reads 00
            end
            apb_read(reg_rx_word, 1'b0, rd);
            check_code("reg_rx_word", exp_code, rd);
            apb_read(reg_status, 1'b0, rd);
            check_bit("rx_valid", 1'b0, rd[st_rx_valid]);  // cleared by the read
            exp_erase = exp_erase + tbl_erase[r];
            apb_read(reg_erasures, 1'b0, rd);
            check_erase("reg_erasures", exp_erase, rd[7:0]);
        end

        // bus errors leave every register alone
        apb_read(reg_poly, 1'b0, poly_snap);
        apb_read(reg_status, 1'b0, stat_snap);
        apb_read(reg_rx_word, 1'b0, word_snap);
        apb_read(reg_erasures, 1'b0, erase_snap);
        apb_write(reg_status, 32'hFFFF_FFFF, 1'b1);
        apb_write(8'h20, 32'h0000_7F7F, 1'b1);
        apb_read(8'h20, 1'b1, rd);
        apb_read(reg_poly, 1'b0, rd);
        check_code("reg_poly", poly_snap, rd);
        apb_read(reg_status, 1'b0, rd);
        check_code("reg_status", stat_snap, rd);
        apb_read(reg_rx_word, 1'b0, rd);
        check_code("reg_rx_word", word_snap, rd);
        apb_read(reg_erasures, 1'b0, rd);
        check_erase("reg_erasures", erase_snap[7:0], rd[7:0]);

        // write clears the count
        apb_write(reg_erasures, 32'h0, 1'b0);
        apb_read(reg_erasures, 1'b0, rd);
        check_erase("reg_erasures", '0, rd[7:0]);

        $display("Done: no errors");
        $finish;
    end

endmodule
